// File: verilog/pmp_pkg.sv
package pmp_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // register width of the core
  localparam int XLEN      = 32;
  // physical address width, rv32 sv32 layout
  localparam int PLEN      = 34;
  // number of pmp entries
  localparam int PMP_CNT   = 16;
  // width of an entry index
  localparam int PMP_IDX_W = 4;
  // one pmpcfg field is a byte
  localparam int CFG_W     = 8;

  //////////////////////////////
  // pmpcfg layout
  //////////////////////////////

  // address matching mode, cfg bits [4:3]
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_a_t;

  // one entry config byte, msb first
  typedef struct packed {
    logic       l;
    logic [1:0] reserved;
    pmp_a_t     a;
    logic       x;
    logic       w;
    logic       r;
  } pmpcfg_t;

  //////////////////////////////
  // access encodings
  //////////////////////////////

  // privilege level, 2 is not implemented
  typedef enum logic [1:0] {
    PRV_U = 2'd0,
    PRV_S = 2'd1,
    PRV_M = 2'd3
  } prv_t;

  // transfer size, same coding as the bus interface
  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HWORD = 3'd1,
    WORD  = 3'd2
  } acc_size_t;

  // csr bank select
  typedef enum logic {
    SEL_CFG  = 1'b0,
    SEL_ADDR = 1'b1
  } csr_sel_t;

  // word address, bits [PLEN-1:2] of a byte address
  typedef logic [PLEN-3:0] pmp_word_t;

endpackage

// File: verilog/pmp_csr.sv
`timescale 1ns/1ns

module pmp_csr
(
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // write strobe and target
  input  logic                                            csr_we_i,
  input  pmp_pkg::csr_sel_t                               csr_sel_i,
  input  logic [pmp_pkg::PMP_IDX_W-1:0]                   csr_idx_i,
  input  logic [pmp_pkg::XLEN-1:0]                        csr_wdata_i,
  // read data of the same target
  output logic [pmp_pkg::XLEN-1:0]                        csr_rdata_o,
  // full register state
  output pmp_pkg::pmpcfg_t [pmp_pkg::PMP_CNT-1:0]         cfg_o,
  output logic [pmp_pkg::PMP_CNT-1:0][pmp_pkg::XLEN-1:0]  addr_o
);

  import pmp_pkg::*;

  //////////////////////////////
  // register state
  //////////////////////////////

  pmpcfg_t [PMP_CNT-1:0]           cfg_q;
  logic    [PMP_CNT-1:0][XLEN-1:0] addr_q;

  // one-hot decode of the written entry
  logic [PMP_CNT-1:0] idx_hit;
  // pmpaddr of this entry is write protected
  logic [PMP_CNT-1:0] addr_lock;
  // qualified per entry write enables
  logic [PMP_CNT-1:0] cfg_we;
  logic [PMP_CNT-1:0] addr_we;

  assign idx_hit = PMP_CNT'(1) << csr_idx_i;

  //////////////////////////////
  // lock rules
  //////////////////////////////

  for (genvar i = 0; i < PMP_CNT; i++)
  begin : g_lock
    if (i == PMP_CNT-1)
    begin : g_last
      // no entry above the last one
      assign addr_lock[i] = cfg_q[i].l;
    end
    else
    begin : g_mid
      // a locked TOR entry also freezes the base address below it
      assign addr_lock[i] = cfg_q[i].l | (cfg_q[i+1].l & (cfg_q[i+1].a == TOR));
    end

    // cfg byte only depends on its own lock bit
    assign cfg_we[i]  = csr_we_i & (csr_sel_i == SEL_CFG) & idx_hit[i] & ~cfg_q[i].l;
    assign addr_we[i] = csr_we_i & (csr_sel_i == SEL_ADDR) & idx_hit[i] & ~addr_lock[i];
  end

  //////////////////////////////
  // register banks
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      // all entries OFF and unlocked
      cfg_q  <= '0;
      addr_q <= '0;
    end
    else
    begin
      for (int i = 0; i < PMP_CNT; i++)
      begin
        // low byte of the write data is the cfg field
        if (cfg_we[i])
          cfg_q[i] <= pmpcfg_t'(csr_wdata_i[CFG_W-1:0]);
        if (addr_we[i])
          addr_q[i] <= csr_wdata_i;
      end
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // always shows the selected register, cfg zero extended
  always_comb
  begin
    if (csr_sel_i == SEL_CFG)
      csr_rdata_o = XLEN'(cfg_q[csr_idx_i]);
    else
      csr_rdata_o = addr_q[csr_idx_i];
  end

  // state towards bounds and checker
  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;

endmodule

// File: verilog/pmp_bounds.sv
`timescale 1ns/1ns

module pmp_bounds
(
  // csr state
  input  pmp_pkg::pmpcfg_t  [pmp_pkg::PMP_CNT-1:0]                  cfg_i,
  input  logic              [pmp_pkg::PMP_CNT-1:0][pmp_pkg::XLEN-1:0] addr_i,
  // word bounds, entry covers lb <= word < ub
  output pmp_pkg::pmp_word_t [pmp_pkg::PMP_CNT-1:0]                 lb_o,
  output pmp_pkg::pmp_word_t [pmp_pkg::PMP_CNT-1:0]                 ub_o
);

  import pmp_pkg::*;

  //////////////////////////////
  // napot mask
  //////////////////////////////

  // clears one bit per trailing one of the address, plus the zero
  // that ends the run, so the region is 2^n words with n zeros
  function automatic pmp_word_t napot_mask(input pmp_word_t a);
    pmp_word_t m;
    logic      run;
    m   = '1;
    run = 1'b1;
    for (int k = 0; k < PLEN-2; k++)
    begin
      if (run)
        m[k] = 1'b0;
      run = run & a[k];
    end
    return m;
  endfunction

  // entry address as a word address
  pmp_word_t entry_adr [PMP_CNT];
  // region mask, NA4 keeps every bit
  pmp_word_t pow_mask  [PMP_CNT];
  // bounds of the entry if read as NA4 or NAPOT
  pmp_word_t pow_lb    [PMP_CNT];
  pmp_word_t pow_ub    [PMP_CNT];
  // lower bound of the entry if read as TOR
  pmp_word_t tor_lb    [PMP_CNT];

  for (genvar i = 0; i < PMP_CNT; i++)
  begin : g_entry
    assign entry_adr[i] = pmp_word_t'(addr_i[i]);
    assign pow_mask[i]  = (cfg_i[i].a == NA4) ? '1 : napot_mask(entry_adr[i]);
    assign pow_lb[i]    = entry_adr[i] & pow_mask[i];
    // size in words is the two's complement of the mask
    assign pow_ub[i]    = pow_lb[i] + (~pow_mask[i] + 1'b1);

    if (i == 0)
    begin : g_first
      // entry 0 starts at address zero
      assign tor_lb[i] = '0;
    end
    else
    begin : g_rest
      // TOR after NA4/NAPOT continues where that region ends,
      // otherwise the previous pmpaddr is the base
      assign tor_lb[i] = (cfg_i[i-1].a inside {NA4, NAPOT}) ? pow_ub[i-1]
                                                            : entry_adr[i-1];
    end
  end

  //////////////////////////////
  // mode select
  //////////////////////////////

  always_comb
  begin
    for (int i = 0; i < PMP_CNT; i++)
    begin
      case (cfg_i[i].a)
        TOR:
        begin
          lb_o[i] = tor_lb[i];
          ub_o[i] = entry_adr[i];
        end
        NA4, NAPOT:
        begin
          lb_o[i] = pow_lb[i];
          ub_o[i] = pow_ub[i];
        end
        // OFF, the checker masks these by mode
        default:
        begin
          lb_o[i] = '0;
          ub_o[i] = '0;
        end
      endcase
    end
  end

endmodule

// File: verilog/pmp_check.sv
`timescale 1ns/1ns

module pmp_check
(
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // access strobe and attributes
  input  logic                                     req_i,
  input  logic [pmp_pkg::PLEN-1:0]                 adr_i,
  input  pmp_pkg::acc_size_t                       size_i,
  input  logic                                     we_i,
  input  logic                                     instr_i,
  input  pmp_pkg::prv_t                            prv_i,
  // entry config and bounds
  input  pmp_pkg::pmpcfg_t   [pmp_pkg::PMP_CNT-1:0] cfg_i,
  input  pmp_pkg::pmp_word_t [pmp_pkg::PMP_CNT-1:0] lb_i,
  input  pmp_pkg::pmp_word_t [pmp_pkg::PMP_CNT-1:0] ub_i,
  // registered result
  output logic                                     chk_valid_o,
  output logic                                     exception_o
);

  import pmp_pkg::*;

  // bytes moved by one transfer
  function automatic logic [2:0] size_bytes(input acc_size_t s);
    case (s)
      BYTE:    return 3'd1;
      HWORD:   return 3'd2;
      // unused codes are taken as a word
      default: return 3'd4;
    endcase
  endfunction

  //////////////////////////////
  // access range
  //////////////////////////////

  logic [PLEN-1:0]      acc_last;
  pmp_word_t            acc_lb;
  pmp_word_t            acc_ub;

  logic [PMP_CNT-1:0]   match_any;
  logic [PMP_CNT-1:0]   match_all;
  logic                 hit;
  logic [PMP_IDX_W-1:0] hit_idx;
  pmpcfg_t              hit_cfg;
  logic                 perm_chk;
  logic                 perm_miss;
  logic                 fault;

  // first and last byte, compared at word granularity
  assign acc_last = adr_i + PLEN'(size_bytes(size_i)) - 1'b1;
  assign acc_lb   = adr_i[PLEN-1:2];
  assign acc_ub   = acc_last[PLEN-1:2];

  for (genvar i = 0; i < PMP_CNT; i++)
  begin : g_match
    // some byte inside, OFF entries never match
    assign match_any[i] = (cfg_i[i].a != OFF) & (acc_lb < ub_i[i]) & (acc_ub >= lb_i[i]);
    // every byte inside
    assign match_all[i] = (acc_lb >= lb_i[i]) & (acc_ub < ub_i[i]);
  end

  //////////////////////////////
  // priority select
  //////////////////////////////

  // scan downwards so the lowest matching entry is kept
  always_comb
  begin
    hit_idx = '0;
    for (int i = PMP_CNT-1; i >= 0; i--)
    begin
      if (match_any[i])
        hit_idx = PMP_IDX_W'(i);
    end
  end

  assign hit     = |match_any;
  assign hit_cfg = cfg_i[hit_idx];

  // permissions count below M, or in M when the entry is locked
  assign perm_chk  = (prv_i != PRV_M) | hit_cfg.l;
  // fetch needs x, otherwise a store needs w and a load needs r
  assign perm_miss = instr_i ? ~hit_cfg.x
                   : we_i    ? ~hit_cfg.w
                   :           ~hit_cfg.r;

  // no match faults below M, partial match always faults
  assign fault = hit ? (~match_all[hit_idx] | (perm_chk & perm_miss))
                     : (prv_i != PRV_M);

  //////////////////////////////
  // result stage
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      chk_valid_o <= 1'b0;
      exception_o <= 1'b0;
    end
    else
    begin
      // one result per request, exception only with valid
      chk_valid_o <= req_i;
      exception_o <= req_i & fault;
    end
  end

endmodule

// File: verilog/pmp_unit.sv
`timescale 1ns/1ns

module pmp_unit
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // csr port
  input  logic                           csr_we_i,
  input  pmp_pkg::csr_sel_t              csr_sel_i,
  input  logic [pmp_pkg::PMP_IDX_W-1:0]  csr_idx_i,
  input  logic [pmp_pkg::XLEN-1:0]       csr_wdata_i,
  output logic [pmp_pkg::XLEN-1:0]       csr_rdata_o,
  // access port
  input  logic                           req_i,
  input  logic [pmp_pkg::PLEN-1:0]       adr_i,
  input  pmp_pkg::acc_size_t             size_i,
  input  logic                           we_i,
  input  logic                           instr_i,
  input  pmp_pkg::prv_t                  prv_i,
  // result, one cycle after req_i
  output logic                           chk_valid_o,
  output logic                           exception_o
);

  import pmp_pkg::*;

  // csr state
  pmpcfg_t   [PMP_CNT-1:0]           cfg_all;
  logic      [PMP_CNT-1:0][XLEN-1:0] addr_all;
  // decoded word bounds
  pmp_word_t [PMP_CNT-1:0]           lb_all;
  pmp_word_t [PMP_CNT-1:0]           ub_all;

  pmp_csr u_csr (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_idx_i   (csr_idx_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg_all),
    .addr_o      (addr_all)
  );

  // combinational, same cycle as the csr state
  pmp_bounds u_bounds (
    .cfg_i  (cfg_all),
    .addr_i (addr_all),
    .lb_o   (lb_all),
    .ub_o   (ub_all)
  );

  pmp_check u_check (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .adr_i       (adr_i),
    .size_i      (size_i),
    .we_i        (we_i),
    .instr_i     (instr_i),
    .prv_i       (prv_i),
    .cfg_i       (cfg_all),
    .lb_i        (lb_all),
    .ub_i        (ub_all),
    .chk_valid_o (chk_valid_o),
    .exception_o (exception_o)
  );

endmodule

// File: testbench/tb_pmp_model.svh
`ifndef TB_PMP_MODEL_SVH
`define TB_PMP_MODEL_SVH

//////////////////////////////
// shadow csr state
//////////////////////////////

pmpcfg_t         m_cfg  [PMP_CNT];
logic [XLEN-1:0] m_addr [PMP_CNT];

function automatic void model_reset();
  for (int i = 0; i < PMP_CNT; i++)
  begin
    m_cfg[i]  = '0;
    m_addr[i] = '0;
  end
endfunction

// own lock guards both registers, a locked TOR above guards the address too
function automatic void model_write(input csr_sel_t sel, input int idx,
                                    input logic [XLEN-1:0] data);
  logic frozen;
  frozen = m_cfg[idx].l;
  if (sel == SEL_CFG)
  begin
    if (!frozen)
      m_cfg[idx] = pmpcfg_t'(data[7:0]);
  end
  else
  begin
    if (idx < PMP_CNT-1)
      frozen = frozen | (m_cfg[idx+1].l & (m_cfg[idx+1].a == TOR));
    if (!frozen)
      m_addr[idx] = data;
  end
endfunction

// cfg byte is zero extended on reads
function automatic logic [XLEN-1:0] model_rdata(input csr_sel_t sel, input int idx);
  return (sel == SEL_CFG) ? XLEN'(m_cfg[idx]) : m_addr[idx];
endfunction

//////////////////////////////
// bounds
//////////////////////////////

// word range of an NA4 or NAPOT entry, ub exclusive
function automatic void model_region(input logic [XLEN-1:0] a, input pmp_a_t mode,
                                     output pmp_word_t lb, output pmp_word_t ub);
  logic [63:0] words;
  int          ones;
  ones = 0;
  while (ones < XLEN && a[ones])
    ones++;
  // napot region is 2^(ones+1) words
  words = (mode == NA4) ? 64'd1 : (64'd1 << (ones + 1));
  lb    = pmp_word_t'({32'd0, a} & ~(words - 64'd1));
  ub    = pmp_word_t'({32'd0, lb} + words);
endfunction

function automatic void model_bounds(input int i, output pmp_word_t lb, output pmp_word_t ub);
  pmp_word_t plb;
  pmp_word_t pub;
  lb = '0;
  ub = '0;
  case (m_cfg[i].a)
    TOR:
    begin
      ub = m_addr[i];
      if (i > 0)
      begin
        lb = m_addr[i-1];
        // after a power of two region the base is where it ends
        if (m_cfg[i-1].a == NA4 || m_cfg[i-1].a == NAPOT)
        begin
          model_region(m_addr[i-1], m_cfg[i-1].a, plb, pub);
          lb = pub;
        end
      end
    end
    NA4, NAPOT:
      model_region(m_addr[i], m_cfg[i].a, lb, ub);
    default:
      lb = '0;
  endcase
endfunction

//////////////////////////////
// access decision
//////////////////////////////

function automatic logic model_fault(input logic [PLEN-1:0] a, input acc_size_t s,
                                     input logic w, input logic f, input prv_t p);
  logic [PLEN-1:0] last;
  pmp_word_t       first_w;
  pmp_word_t       last_w;
  pmp_word_t       lb;
  pmp_word_t       ub;
  logic            allowed;
  last    = a + ((s == BYTE) ? 34'd0 : (s == HWORD) ? 34'd1 : 34'd3);
  first_w = a[PLEN-1:2];
  last_w  = last[PLEN-1:2];
  for (int i = 0; i < PMP_CNT; i++)
  begin
    model_bounds(i, lb, ub);
    if (m_cfg[i].a != OFF && first_w < ub && last_w >= lb)
    begin
      // first entry touched decides, partial coverage faults
      if (first_w < lb || last_w >= ub)
        return 1'b1;
      allowed = f ? m_cfg[i].x : w ? m_cfg[i].w : m_cfg[i].r;
      return (p != PRV_M || m_cfg[i].l) && !allowed;
    end
  end
  // nothing matched, only M gets through
  return p != PRV_M;
endfunction

`endif

// File: testbench/tb_pmp_unit.sv
`timescale 1ns/1ns

module tb_pmp_unit;

  import pmp_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_RANDOM   = 2000;
  localparam int WAIT_MAX   = 16;

  logic                 clk;
  logic                 rst_n;
  logic                 csr_we;
  csr_sel_t             csr_sel;
  logic [PMP_IDX_W-1:0] csr_idx;
  logic [XLEN-1:0]      csr_wdata;
  logic [XLEN-1:0]      csr_rdata;
  logic                 req;
  logic [PLEN-1:0]      adr;
  acc_size_t            size;
  logic                 we;
  logic                 instr;
  prv_t                 prv;
  logic                 chk_valid;
  logic                 exception;

  logic [31:0] lcg_state;
  int          n_pass;
  int          n_fail;
  int          test_err;

  `include "tb_pmp_model.svh"

  pmp_unit dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .csr_we_i    (csr_we),
    .csr_sel_i   (csr_sel),
    .csr_idx_i   (csr_idx),
    .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .req_i       (req),
    .adr_i       (adr),
    .size_i      (size),
    .we_i        (we),
    .instr_i     (instr),
    .prv_i       (prv),
    .chk_valid_o (chk_valid),
    .exception_o (exception)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // lcg step with the halves swapped so the good bits sit low
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic [XLEN-1:0] cfg_word(input logic l, input pmp_a_t a,
                                               input logic [2:0] xwr);
    return {24'h0, l, 2'b00, a, xwr};
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      n_fail++;
      test_err++;
    end
    else
      n_pass++;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    model_reset();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic csr_write(input csr_sel_t sel, input int idx, input logic [XLEN-1:0] data);
    @(negedge clk);
    csr_we    = 1'b1;
    csr_sel   = sel;
    csr_idx   = PMP_IDX_W'(idx);
    csr_wdata = data;
    model_write(sel, idx, data);
    @(negedge clk);
    csr_we = 1'b0;
  endtask

  // select one register and sample the combinational read port
  task automatic csr_read_check(input csr_sel_t sel, input int idx, input logic [XLEN-1:0] exp);
    @(negedge clk);
    csr_sel = sel;
    csr_idx = PMP_IDX_W'(idx);
    @(negedge clk);
    check_value(csr_rdata, exp, $sformatf("csr_rdata_o sel %0d idx %0d", sel, idx));
  endtask

  // one request and the wait for its result
  task automatic access(input logic [PLEN-1:0] a, input acc_size_t s, input logic w,
                        input logic f, input prv_t p, input logic exp_fault);
    int waited;
    @(negedge clk);
    req   = 1'b1;
    adr   = a;
    size  = s;
    we    = w;
    instr = f;
    prv   = p;
    @(negedge clk);
    req    = 1'b0;
    waited = 0;
    while (!chk_valid && waited < WAIT_MAX)
    begin
      @(negedge clk);
      waited++;
    end
    if (!chk_valid)
    begin
      $display("timeout: no chk_valid_o for the access at %h", a);
      n_fail++;
      test_err++;
    end
    else
    begin
      check_value(32'(waited), 32'd0, "result latency");
      check_value(32'(exception), 32'(exp_fault), $sformatf("exception_o at %h", a));
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s %s, %0d errors", name, (test_err == 0) ? "ok" : "bad", test_err);
    test_err = 0;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    logic [31:0] r;
    logic        pend_req;
    logic        pend_exp;
    lcg_state = 32'h8f52_7e53;
    n_pass    = 0;
    n_fail    = 0;
    test_err  = 0;
    rst_n     = 1'b0;
    csr_we    = 1'b0;
    csr_sel   = SEL_CFG;
    csr_idx   = '0;
    csr_wdata = '0;
    req       = 1'b0;
    adr       = '0;
    size      = BYTE;
    we        = 1'b0;
    instr     = 1'b0;
    prv       = PRV_M;
    apply_reset();

    // all csrs clear so only M passes
    for (int i = 0; i < PMP_CNT; i++)
    begin
      csr_read_check(SEL_CFG, i, '0);
      csr_read_check(SEL_ADDR, i, '0);
    end
    access(34'h0_0000_1000, BYTE, 1'b0, 1'b0, PRV_M, 1'b0);
    access(34'h3_ffff_fffc, WORD, 1'b1, 1'b0, PRV_M, 1'b0);
    access(34'h0_0000_0402, HWORD, 1'b0, 1'b1, PRV_M, 1'b0);
    access(34'h0_0000_1000, WORD, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'h0_0000_0010, BYTE, 1'b1, 1'b0, PRV_S, 1'b1);
    end_test("reset");

    // NA4 at 0x400, NAPOT 0x800..0x83f, TOR 0x840..0x87f and 0x880..0x8ff
    apply_reset();
    csr_write(SEL_ADDR, 0, 32'h100);
    csr_write(SEL_CFG, 0, cfg_word(1'b0, NA4, 3'b111));
    csr_write(SEL_ADDR, 1, 32'h207);
    csr_write(SEL_CFG, 1, cfg_word(1'b0, NAPOT, 3'b111));
    csr_write(SEL_ADDR, 2, 32'h220);
    csr_write(SEL_CFG, 2, cfg_word(1'b0, TOR, 3'b111));
    csr_write(SEL_ADDR, 3, 32'h240);
    csr_write(SEL_CFG, 3, cfg_word(1'b0, TOR, 3'b111));
    access(34'h400, WORD, 1'b0, 1'b0, PRV_U, 1'b0);
    access(34'h3fc, WORD, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'h404, BYTE, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'h402, WORD, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'h800, WORD, 1'b0, 1'b0, PRV_U, 1'b0);
    access(34'h83c, WORD, 1'b0, 1'b0, PRV_U, 1'b0);
    access(34'h7ff, HWORD, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'h840, BYTE, 1'b0, 1'b0, PRV_S, 1'b0);
    // straddles two regions that both allow the access
    access(34'h83e, WORD, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'h87e, WORD, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'h8fc, WORD, 1'b0, 1'b0, PRV_U, 1'b0);
    access(34'h900, BYTE, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'h8ff, HWORD, 1'b0, 1'b0, PRV_U, 1'b1);
    end_test("regions");

    // read-only NA4 inside a NAPOT region without r
    apply_reset();
    csr_write(SEL_ADDR, 0, 32'h300);
    csr_write(SEL_CFG, 0, cfg_word(1'b0, NA4, 3'b001));
    csr_write(SEL_ADDR, 1, 32'h307);
    csr_write(SEL_CFG, 1, cfg_word(1'b0, NAPOT, 3'b110));
    access(34'hc00, WORD, 1'b0, 1'b0, PRV_U, 1'b0);
    access(34'hc00, WORD, 1'b1, 1'b0, PRV_U, 1'b1);
    access(34'hc00, WORD, 1'b0, 1'b1, PRV_U, 1'b1);
    access(34'hc10, WORD, 1'b0, 1'b0, PRV_U, 1'b1);
    access(34'hc10, WORD, 1'b1, 1'b0, PRV_U, 1'b0);
    access(34'hc10, WORD, 1'b0, 1'b1, PRV_S, 1'b0);
    access(34'hc00, WORD, 1'b1, 1'b0, PRV_M, 1'b0);
    access(34'hc10, WORD, 1'b0, 1'b0, PRV_M, 1'b0);
    // entry 0 touched first and only partly covers
    access(34'hc02, WORD, 1'b0, 1'b0, PRV_U, 1'b1);
    end_test("priority");

    // locked read-only TOR 0x1000..0x10ff on entry 4
    apply_reset();
    csr_write(SEL_ADDR, 3, 32'h400);
    csr_write(SEL_ADDR, 4, 32'h440);
    csr_write(SEL_CFG, 4, cfg_word(1'b1, TOR, 3'b001));
    csr_write(SEL_CFG, 4, 32'h0f);
    csr_write(SEL_ADDR, 4, 32'h500);
    csr_write(SEL_ADDR, 3, 32'h123);
    csr_write(SEL_ADDR, 2, 32'h55);
    csr_read_check(SEL_CFG, 4, 32'h89);
    csr_read_check(SEL_ADDR, 4, 32'h440);
    csr_read_check(SEL_ADDR, 3, 32'h400);
    csr_read_check(SEL_ADDR, 2, 32'h55);
    access(34'h1000, WORD, 1'b0, 1'b0, PRV_M, 1'b0);
    access(34'h1000, WORD, 1'b1, 1'b0, PRV_M, 1'b1);
    access(34'h10fc, WORD, 1'b0, 1'b1, PRV_M, 1'b1);
    access(34'h1100, WORD, 1'b1, 1'b0, PRV_M, 1'b0);
    access(34'h1080, BYTE, 1'b0, 1'b0, PRV_U, 1'b0);
    access(34'h10fe, HWORD, 1'b1, 1'b0, PRV_U, 1'b1);
    end_test("locking");

    // back to back requests mixed with csr writes
    apply_reset();
    pend_req = 1'b0;
    pend_exp = 1'b0;
    for (int n = 0; n <= N_RANDOM; n++)
    begin
      @(negedge clk);
      // last cycle's result and the read data after its write
      check_value(32'(chk_valid), 32'(pend_req), "chk_valid_o");
      if (pend_req)
        check_value(32'(exception), 32'(pend_exp), "exception_o");
      check_value(csr_rdata, model_rdata(csr_sel, int'(csr_idx)), "csr_rdata_o");
      r         = next_rand();
      csr_we    = (n < N_RANDOM) && (r[0] == 1'b0);
      req       = (n < N_RANDOM) && (r[3:1] != 3'b000);
      csr_sel   = csr_sel_t'(r[4]);
      csr_idx   = r[8:5];
      r         = next_rand();
      // lock is rare so entries stay writable for a while
      csr_wdata = (csr_sel == SEL_CFG) ? {24'h0, (r[15:10] == 6'd0), r[6:0]}
                                       : {21'h0, r[26:16]};
      r         = next_rand();
      adr       = r[31] ? {r[1:0], next_rand()} : {21'h0, r[12:0]};
      size      = acc_size_t'({1'b0, (r[14:13] == 2'd3) ? 2'd2 : r[14:13]});
      we        = r[15];
      instr     = r[16];
      prv       = (r[18:17] == 2'd2) ? PRV_M : prv_t'(r[18:17]);
      // decision uses the state before this cycle's write
      pend_exp  = model_fault(adr, size, we, instr, prv);
      pend_req  = req;
      if (csr_we)
        model_write(csr_sel, int'(csr_idx), csr_wdata);
    end
    end_test("random");

    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+testbench
verilog/pmp_pkg.sv
verilog/pmp_csr.sv
verilog/pmp_bounds.sv
verilog/pmp_check.sv
verilog/pmp_unit.sv
testbench/tb_pmp_unit.sv

// File: Makefile
# Verilator flow for the PMP testbench, all variables can be overridden

VERILATOR ?= verilator
TOP       ?= tb_pmp_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) testbench/tb_pmp_model.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line in the output
test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
